// ==== hdl/noc_pkg.sv ====
package noc_pkg;

    // array geometry
    localparam int PE_ROWS      = 6;
    localparam int PE_COLS      = 7;
    localparam int DIAG_BUSES   = 12;
    localparam int GROUP_PIXELS = 4;

    // last four-pixel group of a line, per layer
    localparam int L2_LAST_ELEM = 7;
    localparam int L3_LAST_ELEM = 3;

    // LAYER2 runs four iterations over the batch; the last one frees it
    localparam int L2_LAST_COUNT = 3;

    // LAYER2 line windows move by seven lines and span eleven
    localparam int L2_LINE_STRIDE = 7;
    localparam int L2_LINE_SPAN   = 11;
    localparam int L2_FINAL_LINE  = 30;

    // LAYER3 covers lines 0..14 in a single pass
    localparam int L3_LINE_SPAN = 15;

    // PE rows that take ifmap lines in LAYER2
    localparam int L2_ACTIVE_ROWS = 5;

    // LAYER3 lower half (rows 3..5) sits four lines further on
    localparam int L3_SPLIT_ROW   = 3;
    localparam int L3_LOWER_SHIFT = 4;

    // LAYER3 packets that go out on two buses at once
    localparam int L3_DUAL_FIRST = 7;
    localparam int L3_DUAL_LAST  = 8;

    typedef logic [7:0]  pixel_t;
    typedef logic [5:0]  line_idx_t;
    typedef logic [5:0]  elem_idx_t;
    typedef logic [4:0]  count_t;
    typedef logic [11:0] diag_mask_t;
    typedef logic [6:0]  pe_row_t;

    // one ready bit per packet index, top bit is a spare
    typedef logic [15:0] line_ready_t;

    typedef enum logic [1:0] {
        LAYER_NONE,
        LAYER2,
        LAYER3
    } layer_t;

endpackage

// ==== hdl/noc_control.sv ====
`timescale 1ns/100ps

module noc_control import noc_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   start_conv,
    input  logic   conv_complete,
    input  layer_t layer_type_in,
    input  count_t complete_count,
    output layer_t layer,
    output logic   conv_load,
    output logic   buffer_free,
    output logic   free_ifmap_buffer
);

    logic last_l2_iter;

    // active layer, held until the next start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer <= LAYER_NONE;
        end else if (start) begin
            layer <= layer_type_in;
        end
    end

    // ifmap_data_in is valid the cycle after start_conv
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conv_load <= 1'b0;
        end else begin
            conv_load <= start_conv;
        end
    end

    assign last_l2_iter = (layer == LAYER2) && (complete_count == count_t'(L2_LAST_COUNT));

    // LAYER3 uses the batch once, LAYER2 only after its fourth iteration
    assign buffer_free = conv_complete && ((layer == LAYER3) || last_l2_iter);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_ifmap_buffer <= 1'b0;
        end else begin
            free_ifmap_buffer <= buffer_free && !start;
        end
    end

endmodule

// ==== hdl/ifmap_pad_buffer.sv ====
`timescale 1ns/100ps

module ifmap_pad_buffer import noc_pkg::*; #(
    parameter int BATCH_LINES = 31,
    parameter int LINE_PIXELS = 32
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      conv_load,
    input  logic      buffer_free,
    input  layer_t    layer,
    input  pixel_t    ifmap_data_in [BATCH_LINES][LINE_PIXELS],
    input  line_idx_t line_ptr,
    input  elem_idx_t elem_ptr,
    output logic      buffer_valid,
    output pixel_t    group_pixels [GROUP_PIXELS]
);

    localparam int PIX_W  = $clog2(LINE_PIXELS);
    localparam int LINE_W = $clog2(BATCH_LINES);

    pixel_t            batch  [BATCH_LINES][LINE_PIXELS];
    pixel_t            padded [BATCH_LINES][LINE_PIXELS];
    logic [LINE_W-1:0] line_sel;
    logic [PIX_W-1:0]  pix_base;

    // padded image shifted down and right by the layer's pad depth
    for (genvar i = 0; i < BATCH_LINES; i++) begin : g_line
        for (genvar j = 0; j < LINE_PIXELS; j++) begin : g_pix
            pixel_t l2_pix;
            pixel_t l3_pix;

            if (i >= 2 && j >= 2) begin : g_l2_data
                assign l2_pix = ifmap_data_in[i-2][j-2];
            end else begin : g_l2_pad
                assign l2_pix = '0;
            end

            if (i >= 1 && j >= 1) begin : g_l3_data
                assign l3_pix = ifmap_data_in[i-1][j-1];
            end else begin : g_l3_pad
                assign l3_pix = '0;
            end

            assign padded[i][j] = (layer == LAYER2) ? l2_pix :
                                  (layer == LAYER3) ? l3_pix : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            batch <= '{default: '0};
        end else if (conv_load) begin
            batch <= padded;
        end else if (buffer_free) begin
            batch <= '{default: '0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buffer_valid <= 1'b0;
        end else if (start) begin
            buffer_valid <= 1'b0;
        end else if (conv_load) begin
            buffer_valid <= 1'b1;
        end else if (buffer_free) begin
            buffer_valid <= 1'b0;
        end
    end

    // line and first pixel of the addressed group
    assign line_sel = LINE_W'(line_ptr);
    assign pix_base = PIX_W'(elem_ptr * GROUP_PIXELS);

    for (genvar p = 0; p < GROUP_PIXELS; p++) begin : g_read
        assign group_pixels[p] = batch[line_sel][pix_base + PIX_W'(p)];
    end

endmodule

// ==== hdl/line_sequencer.sv ====
`timescale 1ns/100ps

module line_sequencer import noc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        start_conv,
    input  logic        conv_load,
    input  logic        buffer_valid,
    input  layer_t      layer,
    input  count_t      complete_count,
    input  line_ready_t line_ready,
    output line_idx_t   line_ptr,
    output line_idx_t   packet_idx,
    output elem_idx_t   elem_ptr,
    output logic        fire,
    output logic        last_elem
);

    logic      enable;
    line_idx_t range_start;
    line_idx_t range_end;
    elem_idx_t last_elem_idx;
    logic      ready;
    logic      step;
    logic      line_wrap;
    logic      final_step;

    // line window and group count for the current layer and iteration
    always_comb begin
        range_start   = '0;
        range_end     = '0;
        last_elem_idx = '0;
        case (layer)
            LAYER2: begin
                if (complete_count <= count_t'(L2_LAST_COUNT)) begin
                    range_start = line_idx_t'(complete_count * L2_LINE_STRIDE);
                end
                if (complete_count == count_t'(L2_LAST_COUNT)) begin
                    range_end = line_idx_t'(L2_FINAL_LINE);
                end else begin
                    range_end = range_start + line_idx_t'(L2_LINE_SPAN - 1);
                end
                last_elem_idx = elem_idx_t'(L2_LAST_ELEM);
            end
            LAYER3: begin
                range_end     = line_idx_t'(L3_LINE_SPAN - 1);
                last_elem_idx = elem_idx_t'(L3_LAST_ELEM);
            end
            default: begin
            end
        endcase
    end

    assign packet_idx = line_ptr - range_start;
    assign last_elem  = (elem_ptr == last_elem_idx);

    // index 16 and up never reads as ready
    assign ready = (packet_idx[5:4] == 2'b00) && line_ready[packet_idx[3:0]];

    // pointers are not valid yet in the cycle they load
    assign step       = enable && !conv_load && ready;
    assign fire       = step && buffer_valid;
    assign line_wrap  = (line_ptr == range_end);
    assign final_step = step && line_wrap && last_elem;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
        end else if (start || final_step) begin
            enable <= 1'b0;
        end else if (start_conv) begin
            enable <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_ptr <= '0;
            elem_ptr <= '0;
        end else if (start) begin
            line_ptr <= '0;
            elem_ptr <= '0;
        end else if (conv_load) begin
            line_ptr <= range_start;
            elem_ptr <= '0;
        end else if (step) begin
            if (line_wrap) begin
                line_ptr <= range_start;
                // hold on the final group so the read address stays in the batch
                if (!last_elem) begin
                    elem_ptr <= elem_ptr + 1'b1;
                end
            end else begin
                line_ptr <= line_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/pe_full_map.sv ====
`timescale 1ns/100ps

module pe_full_map import noc_pkg::*; (
    input  layer_t      layer,
    input  count_t      complete_count,
    input  pe_row_t     pe_full [PE_ROWS],
    output line_ready_t line_ready
);

    logic        last_l2_iter;
    line_ready_t full_hit;

    // the last LAYER2 window has no column 6 work
    assign last_l2_iter = (layer == LAYER2) && (complete_count == count_t'(L2_LAST_COUNT));

    // each PE takes the line on its anti-diagonal
    always_comb begin
        full_hit = '0;
        for (int r = 0; r < PE_ROWS; r++) begin
            for (int c = 0; c < PE_COLS; c++) begin
                if (layer == LAYER2) begin
                    if (r < L2_ACTIVE_ROWS && !(last_l2_iter && c == PE_COLS - 1)) begin
                        full_hit[r + c] = full_hit[r + c] | pe_full[r][c];
                    end
                end else if (layer == LAYER3) begin
                    if (r < L3_SPLIT_ROW) begin
                        full_hit[r + c] = full_hit[r + c] | pe_full[r][c];
                    end else if (c < PE_COLS - 1) begin
                        // lower half, column 6 unused
                        full_hit[r + c + L3_LOWER_SHIFT] =
                            full_hit[r + c + L3_LOWER_SHIFT] | pe_full[r][c];
                    end
                end
            end
        end
    end

    always_comb begin
        line_ready = ~full_hit;
        line_ready[$bits(line_ready_t) - 1] = 1'b0;
    end

endmodule

// ==== hdl/diag_bus_router.sv ====
`timescale 1ns/100ps

module diag_bus_router import noc_pkg::*; (
    input  layer_t     layer,
    input  logic       fire,
    input  logic       last_elem,
    input  line_idx_t  packet_idx,
    input  pixel_t     group_pixels [GROUP_PIXELS],
    output diag_mask_t diag_valid,
    output pixel_t     diag_data [GROUP_PIXELS],
    output line_idx_t  diag_idx
);

    diag_mask_t pattern;
    logic       send;

    always_comb begin
        pattern = '0;
        case (layer)
            LAYER2: begin
                if (packet_idx < line_idx_t'(DIAG_BUSES)) begin
                    pattern = diag_mask_t'(1) << packet_idx;
                end
            end
            LAYER3: begin
                if (packet_idx < line_idx_t'(L3_DUAL_FIRST)) begin
                    pattern = diag_mask_t'(1) << packet_idx;
                end else if (packet_idx <= line_idx_t'(L3_DUAL_LAST)) begin
                    // lines 7 and 8 feed both array halves
                    pattern = (diag_mask_t'(1) << packet_idx) |
                              (diag_mask_t'(1) << (packet_idx - line_idx_t'(L3_LOWER_SHIFT)));
                end else if (packet_idx < line_idx_t'(L3_LINE_SPAN)) begin
                    pattern = diag_mask_t'(1) << (packet_idx - line_idx_t'(L3_LOWER_SHIFT));
                end
            end
            default: begin
            end
        endcase
    end

    assign send       = fire && (pattern != '0);
    assign diag_valid = send ? pattern : '0;
    assign diag_idx   = send ? packet_idx : '0;

    // the last group of a line carries only three real pixels
    for (genvar p = 0; p < GROUP_PIXELS; p++) begin : g_data
        if (p == GROUP_PIXELS - 1) begin : g_tail
            assign diag_data[p] = (send && !last_elem) ? group_pixels[p] : '0;
        end else begin : g_body
            assign diag_data[p] = send ? group_pixels[p] : '0;
        end
    end

endmodule

// ==== hdl/noc_top.sv ====
`timescale 1ns/100ps

module noc_top import noc_pkg::*; #(
    parameter int BATCH_LINES = 31,
    parameter int LINE_PIXELS = 32
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       start_conv,
    input  logic       conv_complete,
    input  layer_t     layer_type_in,
    input  pixel_t     ifmap_data_in [BATCH_LINES][LINE_PIXELS],
    input  pe_row_t    pe_full [PE_ROWS],
    input  count_t     complete_count,
    output logic       free_ifmap_buffer,
    output diag_mask_t diag_valid,
    output pixel_t     diag_data [GROUP_PIXELS],
    output line_idx_t  diag_idx
);

    layer_t      layer;
    logic        conv_load;
    logic        buffer_free;
    logic        buffer_valid;
    line_idx_t   line_ptr;
    line_idx_t   packet_idx;
    elem_idx_t   elem_ptr;
    logic        fire;
    logic        last_elem;
    line_ready_t line_ready;
    pixel_t      group_pixels [GROUP_PIXELS];

    noc_control u_control (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .start_conv        (start_conv),
        .conv_complete     (conv_complete),
        .layer_type_in     (layer_type_in),
        .complete_count    (complete_count),
        .layer             (layer),
        .conv_load         (conv_load),
        .buffer_free       (buffer_free),
        .free_ifmap_buffer (free_ifmap_buffer)
    );

    ifmap_pad_buffer #(
        .BATCH_LINES (BATCH_LINES),
        .LINE_PIXELS (LINE_PIXELS)
    ) u_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .conv_load     (conv_load),
        .buffer_free   (buffer_free),
        .layer         (layer),
        .ifmap_data_in (ifmap_data_in),
        .line_ptr      (line_ptr),
        .elem_ptr      (elem_ptr),
        .buffer_valid  (buffer_valid),
        .group_pixels  (group_pixels)
    );

    line_sequencer u_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .start_conv     (start_conv),
        .conv_load      (conv_load),
        .buffer_valid   (buffer_valid),
        .layer          (layer),
        .complete_count (complete_count),
        .line_ready     (line_ready),
        .line_ptr       (line_ptr),
        .packet_idx     (packet_idx),
        .elem_ptr       (elem_ptr),
        .fire           (fire),
        .last_elem      (last_elem)
    );

    pe_full_map u_full_map (
        .layer          (layer),
        .complete_count (complete_count),
        .pe_full        (pe_full),
        .line_ready     (line_ready)
    );

    diag_bus_router u_router (
        .layer        (layer),
        .fire         (fire),
        .last_elem    (last_elem),
        .packet_idx   (packet_idx),
        .group_pixels (group_pixels),
        .diag_valid   (diag_valid),
        .diag_data    (diag_data),
        .diag_idx     (diag_idx)
    );

endmodule

// ==== include/noc_ref_model.svh ====
`ifndef NOC_REF_MODEL_SVH
`define NOC_REF_MODEL_SVH

// random pixel source for the batch
int unsigned lcg_state = 97;

function automatic pixel_t lcg_pixel();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return pixel_t'(lcg_state >> 16);
endfunction

task automatic fill_batch();
    for (int i = 0; i < BATCH_LINES; i++) begin
        for (int j = 0; j < LINE_PIXELS; j++) begin
            ifmap_data_in[i][j] = lcg_pixel();
        end
    end
endtask

// zero lines and pixels ahead of the image, two for LAYER2, one for LAYER3
function automatic pixel_t padded_pixel(layer_t lay, int line, int pix);
    int d;
    d = (lay == LAYER2) ? 2 : 1;
    if (line < d || pix < d) begin
        return '0;
    end
    return ifmap_data_in[line - d][pix - d];
endfunction

// line window per iteration
function automatic int first_line(layer_t lay, int cnt);
    return (lay == LAYER2) ? cnt * 7 : 0;
endfunction

function automatic int line_total(layer_t lay, int cnt);
    if (lay == LAYER2) begin
        return (cnt == 3) ? 10 : 11;
    end
    return 15;
endfunction

function automatic int group_total(layer_t lay);
    return (lay == LAYER2) ? 8 : 4;
endfunction

// LAYER3 indices 7 and 8 go to both array halves
function automatic diag_mask_t bus_mask(layer_t lay, int k);
    diag_mask_t m;
    m = '0;
    if (lay == LAYER2 || k < 7) begin
        m[k] = 1'b1;
    end else if (k <= 8) begin
        m[k] = 1'b1;
        m[k - 4] = 1'b1;
    end else begin
        m[k - 4] = 1'b1;
    end
    return m;
endfunction

`endif

// ==== tests/tb_noc_top.sv ====
`timescale 1ns/100ps

module tb_noc_top import noc_pkg::*; ();

    localparam int BATCH_LINES = 31;
    localparam int LINE_PIXELS = 32;
    localparam int WAIT_LIMIT  = 200;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       start_conv;
    logic       conv_complete;
    layer_t     layer_type_in;
    pixel_t     ifmap_data_in [BATCH_LINES][LINE_PIXELS];
    pe_row_t    pe_full [PE_ROWS];
    count_t     complete_count;
    logic       free_ifmap_buffer;
    diag_mask_t diag_valid;
    pixel_t     diag_data [GROUP_PIXELS];
    line_idx_t  diag_idx;

    int checks;
    int errors;
    int timeouts;

    `include "noc_ref_model.svh"

    noc_top uut (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .start_conv        (start_conv),
        .conv_complete     (conv_complete),
        .layer_type_in     (layer_type_in),
        .ifmap_data_in     (ifmap_data_in),
        .pe_full           (pe_full),
        .complete_count    (complete_count),
        .free_ifmap_buffer (free_ifmap_buffer),
        .diag_valid        (diag_valid),
        .diag_data         (diag_data),
        .diag_idx          (diag_idx)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_mask(string name, diag_mask_t exp, diag_mask_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: mask expected %03h, got %03h", name, exp, act);
        end
    endtask

    task automatic check_pixel(string name, pixel_t exp, pixel_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: pixel expected %02h, got %02h", name, exp, act);
        end
    endtask

    task automatic check_idx(string name, line_idx_t exp, line_idx_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: index expected %0d, got %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: bit expected %b, got %b", name, exp, act);
        end
    endtask

    task automatic do_start(layer_t lay);
        @(negedge clk);
        layer_type_in = lay;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic do_start_conv();
        @(negedge clk);
        start_conv = 1'b1;
        @(negedge clk);
        start_conv = 1'b0;
    endtask

    // all outputs quiet for a number of cycles
    task automatic expect_idle(string name, int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk);
            check_mask(name, '0, diag_valid);
            check_idx(name, '0, diag_idx);
            for (int p = 0; p < GROUP_PIXELS; p++) begin
                check_pixel(name, '0, diag_data[p]);
            end
            check_bit(name, 1'b0, free_ifmap_buffer);
        end
    endtask

    task automatic wait_packet(string name, output logic got);
        got = 1'b0;
        for (int c = 0; c < WAIT_LIMIT && !got; c++) begin
            @(negedge clk);
            got = (diag_valid != '0);
        end
        if (!got) begin
            timeouts++;
            $display("%s: no packet arrived within %0d cycles", name, WAIT_LIMIT);
        end
    endtask

    task automatic check_packet(string name, layer_t lay, int line, int grp, int k, logic last);
        pixel_t exp_pix;
        check_idx(name, line_idx_t'(k), diag_idx);
        check_mask(name, bus_mask(lay, k), diag_valid);
        for (int p = 0; p < GROUP_PIXELS; p++) begin
            exp_pix = padded_pixel(lay, line, grp * GROUP_PIXELS + p);
            // pixel 3 of the last group is past the line end
            if (last && p == 3) begin
                exp_pix = '0;
            end
            check_pixel(name, exp_pix, diag_data[p]);
        end
    endtask

    // packets in line-major order per group; take 0 means the whole pass
    task automatic expect_pass(string name, layer_t lay, int cnt, int take, int blk_idx);
        int   first;
        int   lines;
        int   groups;
        int   seen;
        logic got;
        first  = first_line(lay, cnt);
        lines  = line_total(lay, cnt);
        groups = group_total(lay);
        seen   = 0;
        for (int g = 0; g < groups; g++) begin
            for (int k = 0; k < lines; k++) begin
                if (take > 0 && seen == take) begin
                    return;
                end
                if (g == 0 && k == blk_idx) begin
                    // sequencer is parked on the blocked index
                    for (int c = 0; c < 30; c++) begin
                        @(negedge clk);
                        check_mask(name, '0, diag_valid);
                    end
                    pe_full = '{default: '0};
                    // the held packet goes out at once and leaves at the next rising edge
                    #1;
                end else begin
                    wait_packet(name, got);
                    if (!got) begin
                        return;
                    end
                end
                check_packet(name, lay, first + k, g, k, g == groups - 1);
                seen++;
            end
        end
    endtask

    task automatic complete_and_check(string name, logic exp);
        @(negedge clk);
        check_bit(name, 1'b0, free_ifmap_buffer);
        conv_complete = 1'b1;
        @(negedge clk);
        check_bit(name, exp, free_ifmap_buffer);
        conv_complete = 1'b0;
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_bit(name, 1'b0, free_ifmap_buffer);
        end
    endtask

    task automatic test_layer3();
        do_start(LAYER3);
        complete_count = '0;
        fill_batch();
        do_start_conv();
        expect_pass("layer3 pass", LAYER3, 0, 0, -1);
        expect_idle("layer3 end", 40);
    endtask

    task automatic test_layer2();
        do_start(LAYER2);
        complete_count = count_t'(0);
        fill_batch();
        do_start_conv();
        expect_pass("layer2 count 0", LAYER2, 0, 0, -1);
        expect_idle("layer2 count 0 end", 40);
        // column 6 is unused in the final iteration
        complete_count = count_t'(3);
        for (int r = 0; r < PE_ROWS; r++) begin
            pe_full[r] = 7'h40;
        end
        fill_batch();
        do_start_conv();
        expect_pass("layer2 count 3", LAYER2, 3, 0, -1);
        expect_idle("layer2 count 3 end", 40);
        pe_full = '{default: '0};
    endtask

    task automatic test_backpressure();
        do_start(LAYER3);
        fill_batch();
        // PE row 1 column 4 sits on index 5
        pe_full[1][4] = 1'b1;
        do_start_conv();
        expect_pass("backpressure", LAYER3, 0, 0, 5);
        expect_idle("backpressure end", 40);
    endtask

    task automatic test_free();
        do_start(LAYER2);
        complete_count = count_t'(1);
        complete_and_check("free layer2 count 1", 1'b0);
        complete_count = count_t'(3);
        complete_and_check("free layer2 count 3", 1'b1);
        do_start(LAYER3);
        fill_batch();
        do_start_conv();
        expect_pass("free layer3 partial", LAYER3, 0, 10, -1);
        complete_and_check("free layer3", 1'b1);
        expect_idle("after free", 100);
        do_start_conv();
        expect_pass("layer3 after free", LAYER3, 0, 0, -1);
        expect_idle("layer3 after free end", 40);
    endtask

    initial begin
        checks         = 0;
        errors         = 0;
        timeouts       = 0;
        rst_n          = 1'b0;
        start          = 1'b0;
        start_conv     = 1'b0;
        conv_complete  = 1'b0;
        layer_type_in  = LAYER_NONE;
        complete_count = '0;
        pe_full        = '{default: '0};
        ifmap_data_in  = '{default: '0};
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        expect_idle("reset", 20);
        test_layer3();
        test_layer2();
        test_backpressure();
        test_free();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hdl/noc_pkg.sv
hdl/noc_control.sv
hdl/ifmap_pad_buffer.sv
hdl/line_sequencer.sv
hdl/pe_full_map.sv
hdl/diag_bus_router.sv
hdl/noc_top.sv
tests/tb_noc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ifmap NoC testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_noc_top -f src.f
out=$(./obj_dir/Vtb_noc_top)
echo "$out"
if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
exit 1
